// ==== flist.f ====
+incdir+verification
verilog/rob_conf_pkg.sv
verilog/rob_pkg.sv
verilog/rob_alloc.sv
verilog/rob_entry_array.sv
verilog/rob_commit.sv
verilog/rob_top.sv
verification/tb_rob.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_rob -o tb_rob_sim \
  && ./obj_dir/tb_rob_sim | tee /dev/stderr | grep -qx '=== PASS ===' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== verification/tb_rob_tasks.svh ====
// --------------------
// reference model state
// --------------------
logic [CMT_ID_W-1:0]     next_id;
logic [CMT_ID_W-1:0]     exp_id  [$];  // groups waiting to commit in age order
logic [DISP-1:0]         exp_grp [$];
logic [31:0]             exp_pc  [$];
logic [DISP*EXC_W-1:0]   exp_exc [$];
logic [DISP-1:0]         exp_br  [$];
logic                    model_kill;
logic [DISP-1:0]         grp_tab [2**CMT_ID_W];  // report contents indexed by cmt id
logic [DISP*EXC_W-1:0]   exc_tab [2**CMT_ID_W];
logic [DISP-1:0]         br_tab  [2**CMT_ID_W];

task automatic check_eq(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
  checks++;
  if (exp_v !== act_v) begin
    $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
    errors++;
  end
endtask

task automatic dispatch(input logic [DISP-1:0] grp, input logic [31:0] pc,
                        input logic [DISP*EXC_W-1:0] exc, input logic [DISP-1:0] br,
                        output logic [CMT_ID_W-1:0] id);
  int waited;
  waited        = 0;
  i_disp_valid  = 1'b1;
  i_disp_grp_id = grp;
  i_disp_pc     = pc;
  while (!o_disp_ready && waited < 100) begin
    @(negedge i_clk);
    waited++;
  end
  if (!o_disp_ready) begin
    $display("%s: dispatch was never accepted", cur_test);
    errors++;
  end
  check_eq("disp_cmt_id", 32'(next_id), 32'(o_disp_cmt_id));
  id = next_id;
  grp_tab[next_id] = grp;
  exc_tab[next_id] = exc;
  br_tab[next_id]  = br;
  exp_id.push_back(next_id);
  exp_grp.push_back(grp);
  exp_pc.push_back(pc);
  exp_exc.push_back(exc);
  exp_br.push_back(br);
  next_id++;
  @(negedge i_clk);  // taken on the edge before this
  i_disp_valid = 1'b0;
endtask

task automatic report(input logic [CMT_ID_W-1:0] id, input int slot,
                      input logic [EXC_W-1:0] cause, input logic br);
  i_done_valid       = 1'b1;
  i_done_cmt_id      = id;
  i_done_slot        = IDX_W'(slot);
  i_done_except      = rob_pkg::except_e'(cause);
  i_done_br_redirect = br;
  @(negedge i_clk);
  i_done_valid = 1'b0;
endtask

// reports every slot of the listed groups in lfsr order
task automatic report_groups(input logic [CMT_ID_W-1:0] ids [$]);
  int pairs [$];
  int j;
  int tmp;
  int id;
  int slot;
  foreach (ids[g]) begin
    for (int k = 0; k < DISP; k++) begin
      if (grp_tab[ids[g]][k]) begin
        pairs.push_back(int'(ids[g]) * DISP + k);
      end
    end
  end
  for (int i = pairs.size() - 1; i > 0; i--) begin
    j        = rand_bits(6) % (i + 1);
    tmp      = pairs[i];
    pairs[i] = pairs[j];
    pairs[j] = tmp;
  end
  foreach (pairs[p]) begin
    id   = pairs[p] / DISP;
    slot = pairs[p] % DISP;
    report(CMT_ID_W'(id), slot, exc_tab[id][slot*EXC_W +: EXC_W], br_tab[id][slot]);
  end
endtask

// predicts one commit from the oldest outstanding group
task automatic check_commit();
  logic [CMT_ID_W-1:0]   id;
  logic [DISP-1:0]       grp;
  logic [DISP-1:0]       br;
  logic [DISP-1:0]       exv;
  logic [DISP-1:0]       oh;
  logic [DISP-1:0]       dead;
  logic [DISP*EXC_W-1:0] exc;
  logic [EXC_W-1:0]      etype;
  logic [31:0]           pc;
  int                    sel;
  if (exp_id.size() == 0) begin
    $display("%s: commit seen with no group outstanding", cur_test);
    errors++;
    return;
  end
  id  = exp_id.pop_front();
  grp = exp_grp.pop_front();
  pc  = exp_pc.pop_front();
  exc = exp_exc.pop_front();
  br  = exp_br.pop_front();
  exv = '0;
  sel = -1;
  for (int k = DISP - 1; k >= 0; k--) begin
    if (grp[k] && exc[k*EXC_W +: EXC_W] != '0) begin
      exv[k] = 1'b1;
    end
    if (grp[k] && (exv[k] || br[k])) begin
      sel = k;  // ends on the lowest
    end
  end
  oh    = '0;
  dead  = '0;
  etype = '0;
  if (sel >= 0) begin
    oh[sel] = 1'b1;
    for (int k = sel + 1; k < DISP; k++) begin
      dead[k] = grp[k];
    end
    if (exv[sel]) begin
      etype = exc[sel*EXC_W +: EXC_W];
    end
  end
  check_eq("cmt_id", 32'(id), 32'(o_cmt_id));
  check_eq("cmt_grp_id", 32'(grp), 32'(o_cmt_grp_id));
  if (model_kill) begin
    check_eq("cmt_all_dead", 1, 32'(o_cmt_all_dead));
    check_eq("cmt_dead_id", 32'(grp), 32'(o_cmt_dead_id));
    check_eq("cmt_except_valid", 0, 32'(o_cmt_except_valid));
    check_eq("disp_ready while flushing", 0, 32'(o_disp_ready));
    if (exp_id.size() == 0) begin
      model_kill = 1'b0;
    end
  end else begin
    check_eq("cmt_all_dead", 0, 32'(o_cmt_all_dead));
    check_eq("cmt_dead_id", 32'(dead), 32'(o_cmt_dead_id));
    check_eq("cmt_except_valid", 32'(oh & exv), 32'(o_cmt_except_valid));
    check_eq("cmt_except_type", 32'(etype), 32'(o_cmt_except_type));
    check_eq("cmt_epc", pc + 32'(4 * ((sel < 0) ? 0 : sel)), o_cmt_epc);
    if ((oh & exv) != '0 && exp_id.size() != 0) begin
      model_kill = 1'b1;  // younger groups get drained
    end
  end
endtask

// ==== verification/tb_rob.sv ====
module tb_rob;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ENTRY_SIZE   = 8;
  localparam int CMT_ID_W     = $clog2(ENTRY_SIZE) + 1;
  localparam int DISP         = rob_conf_pkg::DISP_SIZE;
  localparam int IDX_W        = rob_conf_pkg::DISP_IDX_W;
  localparam int EXC_W        = rob_pkg::EXCEPT_W;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int TOTAL_GROUPS = 19;  // dispatches over all tests

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  logic                o_disp_ready;
  logic [CMT_ID_W-1:0] o_disp_cmt_id;
  logic [DISP-1:0]     i_disp_grp_id;
  logic [31:0]         i_disp_pc;
  logic                i_done_valid;
  logic [CMT_ID_W-1:0] i_done_cmt_id;
  logic [IDX_W-1:0]    i_done_slot;
  rob_pkg::except_e    i_done_except;
  logic                i_done_br_redirect;
  logic                o_cmt_valid;
  logic [CMT_ID_W-1:0] o_cmt_id;
  logic [DISP-1:0]     o_cmt_grp_id;
  logic [DISP-1:0]     o_cmt_dead_id;
  logic                o_cmt_all_dead;
  logic [DISP-1:0]     o_cmt_except_valid;
  rob_pkg::except_e    o_cmt_except_type;
  logic [31:0]         o_cmt_epc;

  int          errors;
  int          checks;
  int          err_start;
  int          cmt_count;
  int          tests_run;
  int          tests_failed;
  string       cur_test;
  logic [31:0] lfsr;

  rob_top #(.ENTRY_SIZE(ENTRY_SIZE)) i_dut (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // --------------------
  // random source
  // --------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  function automatic logic [DISP*EXC_W-1:0] exc_at(input int slot, input rob_pkg::except_e c);
    logic [DISP*EXC_W-1:0] v;
    v = '0;
    v[slot*EXC_W +: EXC_W] = c;
    return v;
  endfunction

  `include "tb_rob_tasks.svh"

  // commit pulse is stable around the falling edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_cmt_valid) begin
      check_commit();
      cmt_count++;
    end
  end

  initial begin
    #((RESET_CYCLES + TOTAL_GROUPS * 50) * CLK_PERIOD);
    $display("watchdog: the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  task automatic wait_commits(input int target);
    int cycles;
    cycles = 0;
    while (cmt_count < target && cycles < 200) begin
      @(posedge i_clk);
      cycles++;
    end
    if (cmt_count < target) begin
      $display("%s: only %0d of %0d commits arrived", cur_test, cmt_count, target);
      errors++;
    end
    @(negedge i_clk);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - err_start);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_in_order();
    logic [CMT_ID_W-1:0] id;
    logic [CMT_ID_W-1:0] ids [$];
    logic [DISP-1:0]     masks [5];
    int                  base;
    start_test("in_order");
    base  = cmt_count;
    masks = '{4'b1111, 4'b0011, 4'b0111, 4'b0001, 4'b1111};
    for (int g = 0; g < 5; g++) begin
      dispatch(masks[g], 32'h1000 + 32'(g * 16), '0, '0, id);
      ids.push_back(id);
    end
    report_groups(ids);
    wait_commits(base + 5);
    end_test();
  endtask

  task automatic test_full();
    logic [CMT_ID_W-1:0] id;
    logic [CMT_ID_W-1:0] ids [$];
    logic [CMT_ID_W-1:0] one [$];
    int                  base;
    start_test("full");
    base = cmt_count;
    for (int g = 0; g < ENTRY_SIZE; g++) begin
      dispatch(4'b0001, 32'h4000 + 32'(g * 16), '0, '0, id);
      ids.push_back(id);
    end
    check_eq("disp_ready when full", 0, 32'(o_disp_ready));
    one.push_back(ids.pop_front());
    report_groups(one);
    wait_commits(base + 1);
    check_eq("disp_ready after one commit", 1, 32'(o_disp_ready));
    report_groups(ids);
    wait_commits(base + ENTRY_SIZE);
    end_test();
  endtask

  task automatic test_exception();
    logic [CMT_ID_W-1:0] id;
    logic [CMT_ID_W-1:0] one [$];
    int                  base;
    start_test("exception");
    base = cmt_count;
    dispatch(4'b1111, 32'h2000, exc_at(1, rob_pkg::EXC_ILLEGAL_INST), '0, id);
    one.push_back(id);
    report_groups(one);
    wait_commits(base + 1);
    end_test();
  endtask

  task automatic test_branch();
    logic [CMT_ID_W-1:0] id;
    logic [CMT_ID_W-1:0] one [$];
    int                  base;
    start_test("branch");
    base = cmt_count;
    dispatch(4'b0111, 32'h3000, '0, 4'b0001, id);
    one.push_back(id);
    report_groups(one);
    wait_commits(base + 1);
    end_test();
  endtask

  task automatic test_flush();
    logic [CMT_ID_W-1:0] id;
    logic [CMT_ID_W-1:0] young_id;
    logic [CMT_ID_W-1:0] one [$];
    int                  base;
    start_test("flush");
    base = cmt_count;
    dispatch(4'b1111, 32'h6000, exc_at(2, rob_pkg::EXC_ECALL), '0, id);
    one.push_back(id);
    dispatch(4'b0011, 32'h6010, exc_at(0, rob_pkg::EXC_BREAKPOINT), '0, young_id);
    dispatch(4'b1111, 32'h6020, '0, '0, id);  // never reported and drained dead
    report(young_id, 0, rob_pkg::EXC_BREAKPOINT, 1'b0);  // younger exception that the flush hides
    report_groups(one);
    wait_commits(base + 3);
    check_eq("disp_ready after flush", 1, 32'(o_disp_ready));
    one.delete();
    dispatch(4'b0101, 32'h6100, '0, '0, id);
    one.push_back(id);
    report_groups(one);
    wait_commits(base + 4);
    end_test();
  endtask

  initial begin
    i_clk              = 1'b0;
    i_reset_n          = 1'b0;
    i_disp_valid       = 1'b0;
    i_disp_grp_id      = '0;
    i_disp_pc          = '0;
    i_done_valid       = 1'b0;
    i_done_cmt_id      = '0;
    i_done_slot        = '0;
    i_done_except      = rob_pkg::EXC_NONE;
    i_done_br_redirect = 1'b0;
    lfsr               = 32'h90cc;
    next_id            = '0;
    model_kill         = 1'b0;
    errors             = 0;
    checks             = 0;
    cmt_count          = 0;
    tests_run          = 0;
    tests_failed       = 0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    start_test("reset");
    check_eq("disp_ready", 1, 32'(o_disp_ready));
    check_eq("cmt_valid", 0, 32'(o_cmt_valid));
    check_eq("disp_cmt_id", 0, 32'(o_disp_cmt_id));
    end_test();

    test_in_order();
    test_full();
    test_exception();
    test_branch();
    test_flush();

    if (exp_id.size() != 0) begin
      $display("%0d expected commits never appeared", exp_id.size());
      errors++;
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog/rob_alloc.sv ====
module rob_alloc #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_disp_valid,
  input  logic                i_pop,
  input  logic                i_killing,
  output logic                o_disp_ready,
  output logic [CMT_ID_W-1:0] o_disp_cmt_id,
  output logic [CMT_ID_W-1:0] o_in_ptr
);

  localparam int CMT_ID_W = $clog2(ENTRY_SIZE) + 1;  // one wrap bit on top

  logic [CMT_ID_W-1:0] r_in_ptr;
  logic [CMT_ID_W-1:0] r_count;   // 0 .. ENTRY_SIZE groups held
  logic                w_full;
  logic                w_accept;

  assign w_full       = (r_count == CMT_ID_W'(ENTRY_SIZE));
  assign o_disp_ready = ~w_full & ~i_killing;  // no new groups while draining
  assign w_accept     = i_disp_valid & o_disp_ready;

  assign o_in_ptr      = r_in_ptr;
  assign o_disp_cmt_id = r_in_ptr;  // new group takes the next slot

  // in-pointer wraps naturally through the extra msb
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr <= '0;
    end else if (w_accept) begin
      r_in_ptr <= r_in_ptr + CMT_ID_W'(1);
    end
  end

  // --------------------
  // occupancy
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_accept, i_pop})
        2'b10:   r_count <= r_count + CMT_ID_W'(1);
        2'b01:   r_count <= r_count - CMT_ID_W'(1);
        default: r_count <= r_count;  // both or neither
      endcase
    end
  end

endmodule

// ==== verilog/rob_commit.sv ====
module rob_commit #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  // head entry
  input  logic                                i_head_valid,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]  i_head_grp_id,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]  i_head_done_grp_id,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]  i_head_except_valid,
  input  rob_pkg::except_e                    i_head_except_type [rob_conf_pkg::DISP_SIZE],
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]  i_head_br_redirect,
  input  logic [rob_conf_pkg::VADDR_W-1:0]    i_head_pc,
  input  logic [CMT_ID_W-1:0]                 i_in_ptr,
  // pointer and state
  output logic [CMT_ID_W-1:0]                 o_out_ptr,
  output logic                                o_pop,
  output logic                                o_killing,
  // commit pulse
  output logic                                o_cmt_valid,
  output logic [CMT_ID_W-1:0]                 o_cmt_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_grp_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_dead_id,
  output logic                                o_cmt_all_dead,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_except_valid,
  output rob_pkg::except_e                    o_cmt_except_type,
  output logic [rob_conf_pkg::VADDR_W-1:0]    o_cmt_epc
);

  localparam int CMT_ID_W = $clog2(ENTRY_SIZE) + 1;
  localparam int DISP     = rob_conf_pkg::DISP_SIZE;
  localparam int IDX_W    = rob_conf_pkg::DISP_IDX_W;

  rob_pkg::cmt_state_e r_state;
  logic [CMT_ID_W-1:0] r_out_ptr;
  logic [CMT_ID_W-1:0] w_out_ptr_next;

  logic             w_all_done;
  logic             w_normal_cmt;
  logic             w_kill_cmt;
  logic [DISP-1:0]  w_upd_cand;    // done slots that change the pc
  logic [DISP-1:0]  w_upd_oh;
  logic [DISP-1:0]  w_except_oh;
  logic [DISP-1:0]  w_above_upd;
  logic [IDX_W-1:0] w_sel_idx;
  rob_pkg::except_e w_sel_type;

  assign o_killing      = (r_state == rob_pkg::CMT_KILL);
  assign w_out_ptr_next = r_out_ptr + CMT_ID_W'(1);

  assign w_all_done   = i_head_valid & (i_head_done_grp_id == i_head_grp_id);
  assign w_normal_cmt = ~o_killing & w_all_done;
  assign w_kill_cmt   = o_killing & i_head_valid;  // no need to wait for done

  // --------------------
  // redirect selection
  // --------------------
  assign w_upd_cand  = (i_head_except_valid | i_head_br_redirect) & i_head_done_grp_id;
  assign w_upd_oh    = w_upd_cand & (~w_upd_cand + DISP'(1));  // lowest set bit
  assign w_except_oh = w_upd_oh & i_head_except_valid;

  // everything strictly above the redirecting slot or nothing without one
  assign w_above_upd = ~(w_upd_oh - DISP'(1)) & ~w_upd_oh;

  always_comb begin
    w_sel_idx  = '0;
    w_sel_type = rob_pkg::EXC_NONE;
    for (int d = 0; d < DISP; d++) begin
      if (w_upd_oh[d]) begin
        w_sel_idx = IDX_W'(d);
      end
      if (w_except_oh[d]) begin
        w_sel_type = i_head_except_type[d];
      end
    end
  end

  // --------------------
  // commit outputs
  // --------------------
  assign o_cmt_valid        = w_normal_cmt | w_kill_cmt;
  assign o_pop              = o_cmt_valid;
  assign o_cmt_id           = r_out_ptr;
  assign o_cmt_grp_id       = i_head_grp_id;
  assign o_cmt_all_dead     = o_killing;
  assign o_cmt_dead_id      = o_killing ? i_head_grp_id : (w_above_upd & i_head_grp_id);
  assign o_cmt_except_valid = o_killing ? '0 : w_except_oh;
  assign o_cmt_except_type  = o_killing ? rob_pkg::EXC_NONE : w_sel_type;
  assign o_cmt_epc          = i_head_pc +
                              (rob_conf_pkg::VADDR_W'(w_sel_idx) * rob_conf_pkg::INST_BYTES);

  assign o_out_ptr = r_out_ptr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_ptr <= '0;
    end else if (o_pop) begin
      r_out_ptr <= w_out_ptr_next;
    end
  end

  // --------------------
  // kill state
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= rob_pkg::CMT_NORMAL;
    end else begin
      case (r_state)
        rob_pkg::CMT_NORMAL: begin
          // younger groups behind the exception must be drained
          if (w_normal_cmt & (|w_except_oh) & (i_in_ptr != w_out_ptr_next)) begin
            r_state <= rob_pkg::CMT_KILL;
          end
        end
        rob_pkg::CMT_KILL: begin
          if (o_pop & (i_in_ptr == w_out_ptr_next)) begin
            r_state <= rob_pkg::CMT_NORMAL;  // last group gone
          end
        end
        default: r_state <= rob_pkg::CMT_NORMAL;
      endcase
    end
  end

endmodule

// ==== verilog/rob_conf_pkg.sv ====
package rob_conf_pkg;

  // --------------------
  // dispatch width
  // --------------------
  localparam int DISP_SIZE  = 4;                  // instructions per group
  localparam int DISP_IDX_W = $clog2(DISP_SIZE);  // slot index width

  // --------------------
  // address space
  // --------------------
  localparam int VADDR_W = 32;  // instruction address width

  // each slot holds one 32-bit instruction
  localparam int INST_BYTES = 4;

endpackage

// ==== verilog/rob_entry_array.sv ====
module rob_entry_array #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                                   i_clk,
  input  logic                                   i_reset_n,
  // dispatch
  input  logic                                   i_disp_valid,
  input  logic                                   i_disp_ready,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]     i_disp_grp_id,
  input  logic [rob_conf_pkg::VADDR_W-1:0]       i_disp_pc,
  input  logic [CMT_ID_W-1:0]                    i_in_ptr,
  // completion
  input  logic                                   i_done_valid,
  input  logic [CMT_ID_W-1:0]                    i_done_cmt_id,
  input  logic [rob_conf_pkg::DISP_IDX_W-1:0]    i_done_slot,
  input  rob_pkg::except_e                       i_done_except,
  input  logic                                   i_done_br_redirect,
  // commit side
  input  logic [CMT_ID_W-1:0]                    i_out_ptr,
  input  logic                                   i_pop,
  output logic                                   o_head_valid,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]     o_head_grp_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]     o_head_done_grp_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]     o_head_except_valid,
  output rob_pkg::except_e                       o_head_except_type [rob_conf_pkg::DISP_SIZE],
  output logic [rob_conf_pkg::DISP_SIZE-1:0]     o_head_br_redirect,
  output logic [rob_conf_pkg::VADDR_W-1:0]       o_head_pc
);

  localparam int CMT_ID_W = $clog2(ENTRY_SIZE) + 1;
  localparam int ENTRY_W  = $clog2(ENTRY_SIZE);
  localparam int DISP     = rob_conf_pkg::DISP_SIZE;

  // control state
  logic [ENTRY_SIZE-1:0] r_valid;
  logic [DISP-1:0]       r_done_grp_id   [ENTRY_SIZE];
  logic [DISP-1:0]       r_except_valid  [ENTRY_SIZE];
  logic [DISP-1:0]       r_br_redirect   [ENTRY_SIZE];

  // payload
  logic                              r_wrap        [ENTRY_SIZE];  // msb of the cmt id
  logic [DISP-1:0]                   r_grp_id      [ENTRY_SIZE];
  logic [rob_conf_pkg::VADDR_W-1:0]  r_pc          [ENTRY_SIZE];
  rob_pkg::except_e                  r_except_type [ENTRY_SIZE][DISP];

  logic [ENTRY_W-1:0] w_in_idx;
  logic [ENTRY_W-1:0] w_out_idx;
  logic [ENTRY_W-1:0] w_done_idx;
  logic               w_load;
  logic               w_done_hit;

  assign w_in_idx   = i_in_ptr[ENTRY_W-1:0];
  assign w_out_idx  = i_out_ptr[ENTRY_W-1:0];
  assign w_done_idx = i_done_cmt_id[ENTRY_W-1:0];
  assign w_load     = i_disp_valid & i_disp_ready;

  // stale reports (freed or reused entry) fall out on the wrap bit
  assign w_done_hit = i_done_valid & r_valid[w_done_idx] &
                      (r_wrap[w_done_idx] == i_done_cmt_id[ENTRY_W]) &
                      r_grp_id[w_done_idx][i_done_slot];

  // --------------------
  // valid and status masks
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      for (int e = 0; e < ENTRY_SIZE; e++) begin
        r_done_grp_id[e]  <= '0;
        r_except_valid[e] <= '0;
        r_br_redirect[e]  <= '0;
      end
    end else begin
      if (w_load) begin
        r_valid[w_in_idx]        <= 1'b1;
        r_done_grp_id[w_in_idx]  <= '0;
        r_except_valid[w_in_idx] <= '0;
        r_br_redirect[w_in_idx]  <= '0;
      end
      if (w_done_hit) begin
        r_done_grp_id[w_done_idx][i_done_slot]  <= 1'b1;
        r_except_valid[w_done_idx][i_done_slot] <= (i_done_except != rob_pkg::EXC_NONE);
        r_br_redirect[w_done_idx][i_done_slot]  <= i_done_br_redirect;
      end
      if (i_pop) begin
        r_valid[w_out_idx] <= 1'b0;  // head leaves
      end
    end
  end

  // group payload is written once at dispatch
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_wrap[w_in_idx]   <= i_in_ptr[ENTRY_W];
      r_grp_id[w_in_idx] <= i_disp_grp_id;
      r_pc[w_in_idx]     <= i_disp_pc;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_done_hit) begin
      r_except_type[w_done_idx][i_done_slot] <= i_done_except;
    end
  end

  // --------------------
  // head view
  // --------------------
  assign o_head_valid        = r_valid[w_out_idx];
  assign o_head_grp_id       = r_grp_id[w_out_idx];
  assign o_head_done_grp_id  = r_done_grp_id[w_out_idx];
  assign o_head_except_valid = r_except_valid[w_out_idx];
  assign o_head_except_type  = r_except_type[w_out_idx];
  assign o_head_br_redirect  = r_br_redirect[w_out_idx];
  assign o_head_pc           = r_pc[w_out_idx];

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

  // --------------------
  // exception causes
  // --------------------
  localparam int EXCEPT_W = 3;

  typedef enum logic [EXCEPT_W-1:0] {
    EXC_NONE           = 3'd0,
    EXC_INST_MISALIGN  = 3'd1,  // instruction address misaligned
    EXC_INST_ACC_FAULT = 3'd2,
    EXC_ILLEGAL_INST   = 3'd3,
    EXC_ECALL          = 3'd4,
    EXC_BREAKPOINT     = 3'd5
  } except_e;

  // --------------------
  // commit side state
  // --------------------
  // KILL drains younger groups after an exception commit
  typedef enum logic {
    CMT_NORMAL = 1'b0,
    CMT_KILL   = 1'b1
  } cmt_state_e;

endpackage

// ==== verilog/rob_top.sv ====
module rob_top #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  // dispatch
  input  logic                                i_disp_valid,
  output logic                                o_disp_ready,
  output logic [CMT_ID_W-1:0]                 o_disp_cmt_id,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]  i_disp_grp_id,
  input  logic [rob_conf_pkg::VADDR_W-1:0]    i_disp_pc,
  // completion reports
  input  logic                                i_done_valid,
  input  logic [CMT_ID_W-1:0]                 i_done_cmt_id,
  input  logic [rob_conf_pkg::DISP_IDX_W-1:0] i_done_slot,
  input  rob_pkg::except_e                    i_done_except,
  input  logic                                i_done_br_redirect,
  // commit
  output logic                                o_cmt_valid,
  output logic [CMT_ID_W-1:0]                 o_cmt_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_grp_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_dead_id,
  output logic                                o_cmt_all_dead,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]  o_cmt_except_valid,
  output rob_pkg::except_e                    o_cmt_except_type,
  output logic [rob_conf_pkg::VADDR_W-1:0]    o_cmt_epc
);

  localparam int CMT_ID_W = $clog2(ENTRY_SIZE) + 1;
  localparam int DISP     = rob_conf_pkg::DISP_SIZE;

  logic [CMT_ID_W-1:0]              w_in_ptr;
  logic [CMT_ID_W-1:0]              w_out_ptr;
  logic                             w_pop;
  logic                             w_killing;

  // head entry fields
  logic                             w_head_valid;
  logic [DISP-1:0]                  w_head_grp_id;
  logic [DISP-1:0]                  w_head_done_grp_id;
  logic [DISP-1:0]                  w_head_except_valid;
  rob_pkg::except_e                 w_head_except_type [DISP];
  logic [DISP-1:0]                  w_head_br_redirect;
  logic [rob_conf_pkg::VADDR_W-1:0] w_head_pc;

  rob_alloc #(.ENTRY_SIZE(ENTRY_SIZE)) u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_pop         (w_pop),
    .i_killing     (w_killing),
    .o_disp_ready  (o_disp_ready),
    .o_disp_cmt_id (o_disp_cmt_id),
    .o_in_ptr      (w_in_ptr)
  );

  rob_entry_array #(.ENTRY_SIZE(ENTRY_SIZE)) u_entries (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_disp_valid        (i_disp_valid),
    .i_disp_ready        (o_disp_ready),
    .i_disp_grp_id       (i_disp_grp_id),
    .i_disp_pc           (i_disp_pc),
    .i_in_ptr            (w_in_ptr),
    .i_done_valid        (i_done_valid),
    .i_done_cmt_id       (i_done_cmt_id),
    .i_done_slot         (i_done_slot),
    .i_done_except       (i_done_except),
    .i_done_br_redirect  (i_done_br_redirect),
    .i_out_ptr           (w_out_ptr),
    .i_pop               (w_pop),
    .o_head_valid        (w_head_valid),
    .o_head_grp_id       (w_head_grp_id),
    .o_head_done_grp_id  (w_head_done_grp_id),
    .o_head_except_valid (w_head_except_valid),
    .o_head_except_type  (w_head_except_type),
    .o_head_br_redirect  (w_head_br_redirect),
    .o_head_pc           (w_head_pc)
  );

  rob_commit #(.ENTRY_SIZE(ENTRY_SIZE)) u_commit (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_head_valid        (w_head_valid),
    .i_head_grp_id       (w_head_grp_id),
    .i_head_done_grp_id  (w_head_done_grp_id),
    .i_head_except_valid (w_head_except_valid),
    .i_head_except_type  (w_head_except_type),
    .i_head_br_redirect  (w_head_br_redirect),
    .i_head_pc           (w_head_pc),
    .i_in_ptr            (w_in_ptr),
    .o_out_ptr           (w_out_ptr),
    .o_pop               (w_pop),
    .o_killing           (w_killing),
    .o_cmt_valid         (o_cmt_valid),
    .o_cmt_id            (o_cmt_id),
    .o_cmt_grp_id        (o_cmt_grp_id),
    .o_cmt_dead_id       (o_cmt_dead_id),
    .o_cmt_all_dead      (o_cmt_all_dead),
    .o_cmt_except_valid  (o_cmt_except_valid),
    .o_cmt_except_type   (o_cmt_except_type),
    .o_cmt_epc           (o_cmt_epc)
  );

endmodule
